//--- logic/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // Address and instruction word width
    localparam int xlen = 32;

    // Byte distance between consecutive instruction pairs
    localparam logic [xlen-1:0] pair_step = 8;

    // Controller states
    typedef enum logic [1:0] {
        idle,
        busy,
        flush
    } fetch_state_t;

    // Next-PC source, listed in priority order
    typedef enum logic [2:0] {
        cause_none,
        cause_trap,
        cause_mret,
        cause_miss,
        cause_taken
    } redirect_cause_t;

endpackage

`default_nettype wire

//--- logic/imem_if.sv
`default_nettype none
`timescale 1ns/1ps

interface imem_if import fetch_pkg::*;;

    // Request side, no back-pressure
    logic            req_valid;
    logic [xlen-1:0] word_index;

    // One-cycle reply after the bank latency
    logic            resp_valid;
    logic [xlen-1:0] rdata;

    modport requester (
        output req_valid,
        output word_index,
        input  resp_valid,
        input  rdata
    );

    modport responder (
        input  req_valid,
        input  word_index,
        output resp_valid,
        output rdata
    );

endinterface

`default_nettype wire

//--- logic/fetch_pair_if.sv
`default_nettype none
`timescale 1ns/1ps

interface fetch_pair_if import fetch_pkg::*;;

    logic            push;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] instr0;
    logic [xlen-1:0] instr1;
    logic            flush;
    // At least one free entry
    logic            space;

    modport producer (
        output push,
        output pc,
        output instr0,
        output instr1,
        output flush,
        input  space
    );

    modport consumer (
        input  push,
        input  pc,
        input  instr0,
        input  instr1,
        input  flush,
        output space
    );

endinterface

`default_nettype wire

//--- logic/imem_bank.sv
`default_nettype none
`timescale 1ns/1ps

module imem_bank import fetch_pkg::*; #(
    parameter int bank_words = 256,
    parameter int latency    = 1
) (
    input  logic            clock,
    input  logic            reset,
    imem_if.responder       port,
    input  logic            wr_en,
    input  logic [xlen-1:0] wr_index,
    input  logic [xlen-1:0] wr_data
);

    localparam int index_bits = $clog2(bank_words);

    logic [xlen-1:0]    mem [bank_words];
    logic [latency-1:0] valid_pipe;
    logic [xlen-1:0]    data_pipe [latency];

    // Read valid shifts along with the data
    always_ff @(posedge clock) begin
        if (reset == 1'b0) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe[0] <= port.req_valid;
            for (int i = 1; i < latency; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clock) begin
        data_pipe[0] <= mem[port.word_index[index_bits-1:0]];
        for (int i = 1; i < latency; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
        if (wr_en) begin
            mem[wr_index[index_bits-1:0]] <= wr_data;
        end
    end

    assign port.resp_valid = valid_pipe[latency-1];
    assign port.rdata      = data_pipe[latency-1];

    // Fetch address must fall inside the loaded program
    assert property (@(posedge clock) disable iff (reset == 1'b0)
        port.req_valid |-> (port.word_index < bank_words));

endmodule

`default_nettype wire

//--- logic/axil_loader.sv
`default_nettype none
`timescale 1ns/1ps

module axil_loader import fetch_pkg::*; #(
    parameter int bank_words = 256
) (
    input  logic              clock,
    input  logic              reset,
    input  logic              awvalid,
    output logic              awready,
    input  logic [xlen-1:0]   awaddr,
    input  logic              wvalid,
    output logic              wready,
    input  logic [xlen-1:0]   wdata,
    input  logic [xlen/8-1:0] wstrb,
    output logic              bvalid,
    input  logic              bready,
    output logic [1:0]        bresp,
    output logic              bank0_wr_en,
    output logic              bank1_wr_en,
    output logic [xlen-1:0]   wr_index,
    output logic [xlen-1:0]   wr_data
);

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    logic accept;
    logic in_range;
    logic full_word;

    // Bit 2 picks the bank, the bits above index the word
    assign wr_index  = awaddr >> 3;
    assign wr_data   = wdata;
    assign in_range  = (wr_index < bank_words);
    // Only full-word strobes update a bank
    assign full_word = &wstrb;

    assign bank0_wr_en = accept && in_range && full_word && !awaddr[2];
    assign bank1_wr_en = accept && in_range && full_word && awaddr[2];

    assign awready = accept;
    assign wready  = accept;

    always_ff @(posedge clock) begin
        if (reset == 1'b0) begin
            accept <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            accept <= awvalid && wvalid && !accept && !bvalid;
            if (accept) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            bresp <= in_range ? resp_okay : resp_slverr;
        end
    end

    assert property (@(posedge clock) disable iff (reset == 1'b0)
        (bvalid && !bready) |=> bvalid);

endmodule

`default_nettype wire

//--- logic/fetch_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

module fetch_ctrl import fetch_pkg::*; #(
    parameter logic [xlen-1:0] reset_pc = '0
) (
    input  logic            clock,
    input  logic            reset,
    input  logic            run,
    input  logic            trap,
    input  logic [xlen-1:0] trap_pc,
    input  logic            mret,
    input  logic [xlen-1:0] mret_pc,
    input  logic            miss,
    input  logic [xlen-1:0] miss_pc,
    input  logic            taken,
    input  logic [xlen-1:0] taken_pc,
    imem_if.requester       bank0,
    imem_if.requester       bank1,
    fetch_pair_if.producer  pair
);

    fetch_state_t    state;
    redirect_cause_t cause;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] target;
    logic [xlen-1:0] req_pc;
    logic [xlen-1:0] data0;
    logic [xlen-1:0] data1;
    logic            pending;
    logic            got0;
    logic            got1;
    logic            complete;
    logic            redirect;
    logic            issue;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Redirect priority
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        cause  = cause_none;
        target = pc;
        if (trap) begin
            cause  = cause_trap;
            target = trap_pc;
        end else if (mret) begin
            cause  = cause_mret;
            target = mret_pc;
        end else if (miss) begin
            cause  = cause_miss;
            target = miss_pc;
        end else if (taken) begin
            cause  = cause_taken;
            target = taken_pc;
        end
    end

    assign redirect = (cause != cause_none);
    assign complete = got0 && got1;
    assign issue    = (state == busy) && !pending && pair.space && !redirect;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // State, PC and reply flags
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clock) begin
        if (reset == 1'b0) begin
            state   <= idle;
            pc      <= reset_pc;
            pending <= 1'b0;
            got0    <= 1'b0;
            got1    <= 1'b0;
        end else begin
            if (bank0.resp_valid) begin
                got0 <= 1'b1;
            end
            if (bank1.resp_valid) begin
                got1 <= 1'b1;
            end
            if (redirect) begin
                pc <= target;
            end else if (issue) begin
                pc <= pc + pair_step;
            end
            case (state)
                idle: begin
                    if (run) begin
                        state <= busy;
                    end
                end
                busy: begin
                    if (issue) begin
                        pending <= 1'b1;
                    end else if (pending && complete) begin
                        // Pushed, or dropped by a redirect
                        pending <= 1'b0;
                        got0    <= 1'b0;
                        got1    <= 1'b0;
                    end else if (pending && redirect) begin
                        pending <= 1'b0;
                        state   <= flush;
                    end
                end
                flush: begin
                    // Stale pair fully drained
                    if (complete) begin
                        state <= busy;
                        got0  <= 1'b0;
                        got1  <= 1'b0;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (issue) begin
            req_pc <= pc;
        end
        if (bank0.resp_valid) begin
            data0 <= bank0.rdata;
        end
        if (bank1.resp_valid) begin
            data1 <= bank1.rdata;
        end
    end

    // Even word from bank 0, odd word from bank 1
    assign bank0.req_valid  = issue;
    assign bank0.word_index = pc >> 3;
    assign bank1.req_valid  = issue;
    assign bank1.word_index = (pc + 4) >> 3;

    assign pair.push   = (state == busy) && pending && complete && !redirect;
    assign pair.pc     = req_pc;
    assign pair.instr0 = data0;
    assign pair.instr1 = data1;
    assign pair.flush  = redirect;

    assert property (@(posedge clock) disable iff (reset == 1'b0)
        pc[2:0] == 3'b000);

    // Buffer had room when the pair was sent
    assert property (@(posedge clock) disable iff (reset == 1'b0)
        pair.push |-> pair.space);

    // A redirected pair never reaches the buffer
    assert property (@(posedge clock) disable iff (reset == 1'b0)
        (cause != cause_none) |=> !pair.push);

endmodule

`default_nettype wire

//--- logic/fetch_buffer.sv
`default_nettype none
`timescale 1ns/1ps

module fetch_buffer import fetch_pkg::*; #(
    parameter int buffer_depth = 4
) (
    input  logic            clock,
    input  logic            reset,
    fetch_pair_if.consumer  pair,
    output logic            out_valid,
    output logic [xlen-1:0] out_pc,
    output logic [xlen-1:0] out_instr0,
    output logic [xlen-1:0] out_instr1,
    input  logic            out_ready
);

    localparam int ptr_bits   = (buffer_depth > 1) ? $clog2(buffer_depth) : 1;
    localparam int count_bits = $clog2(buffer_depth + 1);

    logic [xlen-1:0]       pc_mem     [buffer_depth];
    logic [xlen-1:0]       instr0_mem [buffer_depth];
    logic [xlen-1:0]       instr1_mem [buffer_depth];
    logic [ptr_bits-1:0]   wr_ptr;
    logic [ptr_bits-1:0]   rd_ptr;
    logic [count_bits-1:0] count;
    logic                  pop;

    function automatic logic [ptr_bits-1:0] next_ptr(input logic [ptr_bits-1:0] ptr);
        if (ptr == ptr_bits'(buffer_depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign out_valid  = (count != '0);
    assign pop        = out_valid && out_ready;
    assign pair.space = (count < buffer_depth);

    always_ff @(posedge clock) begin
        if (reset == 1'b0 || pair.flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (pair.push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (pair.push && !pop) begin
                count <= count + 1'b1;
            end else if (!pair.push && pop) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (pair.push) begin
            pc_mem[wr_ptr]     <= pair.pc;
            instr0_mem[wr_ptr] <= pair.instr0;
            instr1_mem[wr_ptr] <= pair.instr1;
        end
    end

    assign out_pc     = pc_mem[rd_ptr];
    assign out_instr0 = instr0_mem[rd_ptr];
    assign out_instr1 = instr1_mem[rd_ptr];

    assert property (@(posedge clock) disable iff (reset == 1'b0)
        count <= buffer_depth);

endmodule

`default_nettype wire

//--- logic/fetch_unit_top.sv
`default_nettype none
`timescale 1ns/1ps

module fetch_unit_top import fetch_pkg::*; #(
    parameter int              bank_words    = 256,
    parameter int              bank0_latency = 1,
    parameter int              bank1_latency = 3,
    parameter int              buffer_depth  = 4,
    parameter logic [xlen-1:0] reset_pc      = '0
) (
    input  logic              clock,
    input  logic              reset,
    // Program load
    input  logic              awvalid,
    output logic              awready,
    input  logic [xlen-1:0]   awaddr,
    input  logic              wvalid,
    output logic              wready,
    input  logic [xlen-1:0]   wdata,
    input  logic [xlen/8-1:0] wstrb,
    output logic              bvalid,
    input  logic              bready,
    output logic [1:0]        bresp,
    input  logic              run,
    // Redirects
    input  logic              trap,
    input  logic [xlen-1:0]   trap_pc,
    input  logic              mret,
    input  logic [xlen-1:0]   mret_pc,
    input  logic              miss,
    input  logic [xlen-1:0]   miss_pc,
    input  logic              taken,
    input  logic [xlen-1:0]   taken_pc,
    // Decode side
    output logic              out_valid,
    input  logic              out_ready,
    output logic [xlen-1:0]   out_pc,
    output logic [xlen-1:0]   out_instr0,
    output logic [xlen-1:0]   out_instr1
);

    logic            bank0_wr_en;
    logic            bank1_wr_en;
    logic [xlen-1:0] wr_index;
    logic [xlen-1:0] wr_data;

    imem_if       bank0_port ();
    imem_if       bank1_port ();
    fetch_pair_if pair_port ();

    axil_loader #(.bank_words(bank_words)) i_axil_loader (
        .clock, .reset,
        .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
        .bvalid, .bready, .bresp,
        .bank0_wr_en, .bank1_wr_en, .wr_index, .wr_data
    );

    imem_bank #(.bank_words(bank_words), .latency(bank0_latency)) i_bank0 (
        .clock, .reset, .port(bank0_port.responder),
        .wr_en(bank0_wr_en), .wr_index, .wr_data
    );

    imem_bank #(.bank_words(bank_words), .latency(bank1_latency)) i_bank1 (
        .clock, .reset, .port(bank1_port.responder),
        .wr_en(bank1_wr_en), .wr_index, .wr_data
    );

    fetch_ctrl #(.reset_pc(reset_pc)) i_fetch_ctrl (
        .clock, .reset, .run,
        .trap, .trap_pc, .mret, .mret_pc, .miss, .miss_pc, .taken, .taken_pc,
        .bank0(bank0_port.requester), .bank1(bank1_port.requester),
        .pair(pair_port.producer)
    );

    fetch_buffer #(.buffer_depth(buffer_depth)) i_fetch_buffer (
        .clock, .reset, .pair(pair_port.consumer),
        .out_valid, .out_pc, .out_instr0, .out_instr1, .out_ready
    );

endmodule

`default_nettype wire

//--- tests/fetch_unit_tb.sv
`default_nettype none
`timescale 1ns/1ps

module fetch_unit_tb import fetch_pkg::*;;

    localparam int              bank_words = 32;
    localparam logic [xlen-1:0] reset_pc   = 32'h0;
    localparam int              period     = 4;
    // Pops requested by the stimulus, and a generous bound per pair
    localparam int pairs_checked  = 18 + 7 * 4;
    localparam int cycles_per_pair = 24;
    localparam int load_cycles     = (2 * bank_words + 1) * 6;
    localparam int timeout_cycles  = load_cycles + pairs_checked * cycles_per_pair + 200;

    logic            clock;
    logic            reset;
    logic            awvalid;
    logic            awready;
    logic [xlen-1:0] awaddr;
    logic            wvalid;
    logic            wready;
    logic [xlen-1:0] wdata;
    logic [3:0]      wstrb;
    logic            bvalid;
    logic            bready;
    logic [1:0]      bresp;
    logic            run;
    logic            trap;
    logic [xlen-1:0] trap_pc;
    logic            mret;
    logic [xlen-1:0] mret_pc;
    logic            miss;
    logic [xlen-1:0] miss_pc;
    logic            taken;
    logic [xlen-1:0] taken_pc;
    logic            out_valid;
    logic            out_ready;
    logic [xlen-1:0] out_pc;
    logic [xlen-1:0] out_instr0;
    logic [xlen-1:0] out_instr1;

    logic [xlen-1:0] ref_mem [2 * bank_words];
    logic [xlen-1:0] exp_pc;
    logic [63:0]     want;
    int              pops;
    int              checks;
    int              errors;

    fetch_unit_top #(
        .bank_words(bank_words), .bank0_latency(1), .bank1_latency(3),
        .buffer_depth(4), .reset_pc(reset_pc)
    ) i_fetch_unit_top (
        .clock, .reset,
        .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
        .bvalid, .bready, .bresp, .run,
        .trap, .trap_pc, .mret, .mret_pc, .miss, .miss_pc, .taken, .taken_pc,
        .out_valid, .out_ready, .out_pc, .out_instr0, .out_instr1
    );

    initial begin
        clock = 1'b0;
        forever #(period / 2) clock = ~clock;
    end

    // Word at pc in the low half, word at pc+4 in the high half
    function automatic logic [63:0] expected_pair(input logic [xlen-1:0] pc);
        return {ref_mem[int'(pc >> 2) + 1], ref_mem[int'(pc >> 2)]};
    endfunction

    // Trap, then mret, then miss, then taken
    function automatic logic [xlen-1:0] redirect_target(input logic [3:0] mask,
            input logic [xlen-1:0] t_pc, m_pc, s_pc, k_pc);
        if (mask[3]) return t_pc;
        if (mask[2]) return m_pc;
        if (mask[1]) return s_pc;
        return k_pc;
    endfunction

    // Targets of different sources never coincide
    function automatic logic [xlen-1:0] random_target(input int slot);
        return (slot * 3 + $urandom_range(0, 2)) * 8;
    endfunction

    task automatic axi_write(input logic [xlen-1:0] addr, input logic [xlen-1:0] data,
            output logic [1:0] resp);
        @(posedge clock);
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= 4'hf;
        @(posedge clock);
        while (!awready && !wready) @(posedge clock);
        assert (awready && wready) else begin
            errors++;
            $display("FAILED at %0t: awready %b wready %b, expected both high", $time,
                awready, wready);
        end
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        bready  <= 1'b1;
        @(posedge clock);
        while (!bvalid) @(posedge clock);
        resp = bresp;
        bready <= 1'b0;
    endtask

    task automatic consume(input int n, input bit random_ready);
        int target;
        target = pops + n;
        while (pops < target) begin
            @(posedge clock);
            out_ready <= random_ready ? ($urandom_range(0, 1) == 1) : 1'b1;
        end
    endtask

    task automatic idle_random(input int n);
        repeat (n) begin
            @(posedge clock);
            out_ready <= ($urandom_range(0, 1) == 1);
        end
    endtask

    // One-cycle pulse on the redirect inputs selected by mask
    task automatic pulse_redirect(input logic [3:0] mask);
        @(posedge clock);
        {trap, mret, miss, taken} <= mask;
        trap_pc  <= random_target(0);
        mret_pc  <= random_target(1);
        miss_pc  <= random_target(2);
        taken_pc <= random_target(3);
        @(posedge clock);
        {trap, mret, miss, taken} <= 4'b0000;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checker on the decode side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clock) begin
        if (reset == 1'b1) begin
            // A pop in the redirect cycle still belongs to the old stream
            if (out_valid && out_ready) begin
                want = expected_pair(exp_pc);
                checks++;
                assert (out_pc === exp_pc) else begin
                    errors++;
                    $display("FAILED at %0t: out_pc %h, expected %h", $time, out_pc, exp_pc);
                end
                assert (out_instr0 === want[31:0] && out_instr1 === want[63:32]) else begin
                    errors++;
                    $display("FAILED at %0t: pair at %h is %h %h, expected %h %h", $time,
                        exp_pc, out_instr0, out_instr1, want[31:0], want[63:32]);
                end
                exp_pc = exp_pc + 8;
                pops <= pops + 1;
            end
            if (trap || mret || miss || taken) begin
                exp_pc = redirect_target({trap, mret, miss, taken},
                    trap_pc, mret_pc, miss_pc, taken_pc);
            end
        end
    end

    initial begin
        repeat (timeout_cycles) @(posedge clock);
        $display("Timeout after %0d cycles, the run did not finish", timeout_cycles);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        logic [1:0] resp;
        logic [3:0] mask;
        void'($urandom(32'h3a775f3e));
        exp_pc = reset_pc;
        pops   = 0;
        checks = 0;
        errors = 0;
        reset     <= 1'b0;
        {awvalid, wvalid, bready, run, out_ready} <= 5'b0;
        awaddr    <= '0;
        wdata     <= '0;
        wstrb     <= '0;
        {trap, mret, miss, taken} <= 4'b0000;
        {trap_pc, mret_pc, miss_pc, taken_pc} <= '0;
        repeat (2) @(posedge clock);
        reset <= 1'b1;

        // Program load, then one write past the end of both banks
        for (int w = 0; w < 2 * bank_words; w++) begin
            ref_mem[w] = $urandom;
            axi_write(w * 4, ref_mem[w], resp);
            assert (resp == 2'b00) else begin
                errors++;
                $display("FAILED at %0t: bresp %b for word %0d, expected OKAY", $time, resp, w);
            end
        end
        axi_write(bank_words * 8, $urandom, resp);
        assert (resp == 2'b10) else begin
            errors++;
            $display("FAILED at %0t: bresp %b out of range, expected SLVERR", $time, resp);
        end

        @(posedge clock);
        run <= 1'b1;
        consume(10, 1'b0);
        consume(8, 1'b1);

        for (int i = 0; i < 4; i++) begin
            idle_random($urandom_range(0, 5));
            pulse_redirect(4'b1000 >> i);
            consume(4, 1'b1);
        end

        repeat (3) begin
            do begin
                mask = $urandom_range(0, 15);
            end while (int'(mask[0]) + int'(mask[1]) + int'(mask[2]) + int'(mask[3]) < 2);
            idle_random($urandom_range(0, 5));
            pulse_redirect(mask);
            consume(4, 1'b1);
        end

        // Stall the stream so fetch stays inside the banks
        @(posedge clock);
        out_ready <= 1'b0;
        repeat (10) @(posedge clock);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
logic/fetch_pkg.sv
logic/imem_if.sv
logic/fetch_pair_if.sv
logic/imem_bank.sv
logic/axil_loader.sv
logic/fetch_ctrl.sv
logic/fetch_buffer.sv
logic/fetch_unit_top.sv
tests/fetch_unit_tb.sv
